/* cpuTop.f */
cpuPkg.sv
memBusIf.sv
controlUnit.sv
instructionFetch.sv
registerFile.sv
aluUnit.sv
dataAccess.sv
memoryArbiter.sv
cpuTop.sv
cpuTop_properties.sv
cpuTopTb.sv

/* cpuTopTb.sv */
`timescale 1ns/1ps
module cpuTopTb
    import cpuPkg::*;
();

    localparam int timeoutCycles = 3000;

    logic    clock;
    logic    reset;
    addrWord memAddress;
    logic    memWrite;
    dataWord memWriteData;
    dataWord memReadData;

    dataWord  memory [256];
    instrWord code [$];
    int       cycleCount = 0;
    int       checkPass = 0;
    int       checkFail = 0;

    cpuTop u_dut (
        .clock, .reset, .memAddress, .memWrite, .memWriteData, .memReadData
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    assign memReadData = memory[memAddress];    // Combinational read

    always @(posedge clock) begin
        if (memWrite) begin
            memory[memAddress] <= memWriteData;
        end
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic instrWord encodeAlu(input opcodeField op, input regIndex dst,
                                           input regIndex srcA, input regIndex srcB);
        return {op, 2'b00, dst, 2'b00, srcA, 2'b00, srcB};
    endfunction

    function automatic instrWord encodeLoadImm(input regIndex r, input dataWord value);
        return {opLd, 2'b00, r, value};
    endfunction

    function automatic instrWord encodeLoadDirect(input regIndex r, input addrWord address);
        return {opLd, 2'b01, r, address};  // Mode bit set
    endfunction

    function automatic instrWord encodeStore(input regIndex r, input addrWord address);
        return {opSt, 2'b00, r, address};
    endfunction

    function automatic instrWord encodeJump(input opcodeField op, input addrWord target);
        return {op, 4'h0, target};
    endfunction

    task automatic beginTest();
        @(negedge clock);
        reset = 1'b1;
        for (int i = 0; i < 256; i++) begin
            memory[i] <= dataWord'(i * 37 + 11);
        end
        code.delete();
    endtask

    task automatic runProgram(input int slots);
        code.push_back(encodeJump(opBra, addrWord'(2 * code.size())));   // Halt loop
        foreach (code[i]) begin
            memory[2 * i]     <= code[i][7:0];
            memory[2 * i + 1] <= code[i][15:8];
        end
        repeat (10) @(negedge clock);
        reset = 1'b0;
        repeat (4 * slots) @(negedge clock);    // At most 4 cycles per instruction
    endtask

    task automatic checkByte(input string name, input addrWord address, input dataWord expected);
        if (memory[address] !== expected) begin
            $display("CHECK FAILED %s: mem[%02h] expected %02h actual %02h",
                     name, address, expected, memory[address]);
            checkFail++;
        end else begin
            checkPass++;
        end
    endtask

    task automatic reportTest(input string name, input int failsBefore);
        if (checkFail == failsBefore) begin
            $display("Test %s finished: passed", name);
        end else begin
            $display("Test %s finished: %0d checks failed", name, checkFail - failsBefore);
        end
    endtask

    task automatic logicTest();
        int      failsBefore;
        dataWord a;
        dataWord b;
        failsBefore = checkFail;
        a = 8'hCA;
        b = 8'h6F;
        beginTest();
        code.push_back(encodeLoadImm(2'd0, a));
        code.push_back(encodeLoadImm(2'd1, b));
        code.push_back(encodeAlu(opAnd, 2'd2, 2'd0, 2'd1));
        code.push_back(encodeStore(2'd2, 8'h80));
        code.push_back(encodeAlu(opOr, 2'd2, 2'd0, 2'd1));
        code.push_back(encodeStore(2'd2, 8'h81));
        code.push_back(encodeAlu(opNot, 2'd3, 2'd0, 2'd0));
        code.push_back(encodeStore(2'd3, 8'h82));
        runProgram(12);
        checkByte("logic AND", 8'h80, a & b);
        checkByte("logic OR", 8'h81, a | b);
        checkByte("logic NOT", 8'h82, ~a);
        reportTest("logic", failsBefore);
    endtask

    task automatic arithTest(input string name, input dataWord a, input dataWord b);
        int failsBefore;
        failsBefore = checkFail;
        beginTest();
        code.push_back(encodeLoadImm(2'd0, a));
        code.push_back(encodeLoadImm(2'd1, b));
        code.push_back(encodeAlu(opAdd, 2'd2, 2'd0, 2'd1));
        code.push_back(encodeStore(2'd2, 8'h90));
        code.push_back(encodeAlu(opSub, 2'd3, 2'd1, 2'd0));   // b minus a
        code.push_back(encodeStore(2'd3, 8'h91));
        runProgram(10);
        checkByte({name, " ADD"}, 8'h90, dataWord'((int'(a) + int'(b)) % 256));
        checkByte({name, " SUB"}, 8'h91, dataWord'((int'(b) - int'(a) + 256) % 256));
        reportTest(name, failsBefore);
    endtask

    task automatic shiftMoveTest();
        int      failsBefore;
        dataWord a;
        failsBefore = checkFail;
        a = 8'h96;
        beginTest();
        code.push_back(encodeLoadImm(2'd0, a));
        code.push_back(encodeAlu(opLsr, 2'd1, 2'd0, 2'd0));
        code.push_back(encodeStore(2'd1, 8'hA0));
        code.push_back(encodeAlu(opLsl, 2'd2, 2'd0, 2'd0));
        code.push_back(encodeStore(2'd2, 8'hA1));
        code.push_back(encodeAlu(opMov, 2'd3, 2'd0, 2'd0));
        code.push_back(encodeStore(2'd3, 8'hA2));
        runProgram(10);
        checkByte("shift LSR", 8'hA0, a / 2);
        checkByte("shift LSL", 8'hA1, dataWord'((int'(a) * 2) % 256));
        checkByte("shift MOV", 8'hA2, a);
        reportTest("shift and move", failsBefore);
    endtask

    task automatic directLoadTest();
        int      failsBefore;
        dataWord source;
        failsBefore = checkFail;
        source = dataWord'($urandom);
        beginTest();
        memory[8'hB0] <= source;
        memory[8'hB8] <= ~source;   // Differs from the expected byte
        code.push_back(encodeLoadDirect(2'd1, 8'hB0));
        code.push_back(encodeStore(2'd1, 8'hB8));
        runProgram(6);
        checkByte("direct load", 8'hB8, source);
        reportTest("direct load", failsBefore);
    endtask

    task automatic branchTest();
        int      failsBefore;
        dataWord count;
        failsBefore = checkFail;
        count = 8'd5;
        beginTest();
        memory[8'hC1] <= 8'hA5;
        code.push_back(encodeLoadImm(2'd0, count));
        code.push_back(encodeLoadImm(2'd1, 8'd1));
        code.push_back(encodeLoadImm(2'd2, 8'd0));
        code.push_back(encodeAlu(opAdd, 2'd2, 2'd2, 2'd1));   // Loop body at address 6
        code.push_back(encodeAlu(opSub, 2'd0, 2'd0, 2'd1));
        code.push_back(encodeJump(opBne, 8'd6));
        code.push_back(encodeStore(2'd2, 8'hC0));
        code.push_back(encodeJump(opBra, 8'd18));   // Over the next ST to the halt loop
        code.push_back(encodeStore(2'd2, 8'hC1));
        runProgram(24);
        checkByte("branch loop count", 8'hC0, count);
        checkByte("branch skipped store", 8'hC1, 8'hA5);
        reportTest("branches", failsBefore);
    endtask

    initial begin
        reset = 1'b1;
        void'($urandom(79602));
        logicTest();
        arithTest("arith fixed", 8'hF0, 8'h25);
        arithTest("arith random", dataWord'($urandom), dataWord'($urandom));
        shiftMoveTest();
        directLoadTest();
        branchTest();
        $display("Checks passed: %0d, checks failed: %0d", checkPass, checkFail);
        if (checkFail == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* cpuTop_properties.sv */
`timescale 1ns/1ps
module cpuTopProperties
    import cpuPkg::*;
(
    input logic    clock,
    input logic    reset,
    input addrWord memAddress,
    input logic    memWrite,
    input dataWord memWriteData
);

    logic resetPrevious;

    always @(posedge clock) begin
        resetPrevious <= reset;    // Reset seen on the previous edge
    end

    writeQuietAroundReset: assert property (@(posedge clock) resetPrevious |-> !memWrite)
        else $error("memWrite high while in reset or in the cycle after it");

    writeBusKnown: assert property (@(posedge clock)
        memWrite |-> !$isunknown({memAddress, memWriteData}))
        else $error("memAddress or memWriteData unknown during a write");

    singleCycleWrite: assert property (@(posedge clock) memWrite |=> !memWrite)
        else $error("memWrite high in two consecutive cycles");

endmodule

bind cpuTop cpuTopProperties u_properties (.*);

/* cpuTop.sv */
`timescale 1ns/1ps
module cpuTop
    import cpuPkg::*;
#(
    parameter addrWord resetVector   = '0,
    parameter int      registerCount = 4
) (
    input  logic    clock,
    input  logic    reset,
    output addrWord memAddress,
    output logic    memWrite,
    output dataWord memWriteData,
    input  dataWord memReadData
);

    memBusIf fetchBus ();
    memBusIf dataBus ();

    instrWord instruction;
    logic     zeroFlag;
    logic     fetchDone;
    logic     fetchLowStrobe;
    logic     fetchHighStrobe;
    logic     branchTaken;
    addrWord  branchTarget;
    logic     loadRequest;
    logic     storeRequest;
    addrWord  dataAddress;
    dataWord  storeData;
    logic     accessDone;
    dataWord  loadData;
    regIndex  readA;
    regIndex  readB;
    dataWord  operandA;
    dataWord  operandB;
    dataWord  aluResult;
    logic     writeEnable;
    regIndex  writeIndex;
    dataWord  writeData;
    aluOp     aluSelect;
    logic     flagEnable;

    controlUnit u_controlUnit (
        .clock, .reset, .instruction, .zeroFlag, .fetchDone,
        .fetchLowStrobe, .fetchHighStrobe, .branchTaken, .branchTarget,
        .loadRequest, .storeRequest, .dataAddress, .storeData,
        .accessDone, .loadData, .readA, .readB, .operandB, .aluResult,
        .writeEnable, .writeIndex, .writeData, .aluSelect, .flagEnable
    );

    instructionFetch #(.resetVector(resetVector)) u_instructionFetch (
        .clock, .reset, .fetchLowStrobe, .fetchHighStrobe,
        .branchTaken, .branchTarget, .fetchDone, .instruction,
        .bus(fetchBus)
    );

    registerFile #(.registerCount(registerCount)) u_registerFile (
        .clock, .reset, .readA, .readB, .operandA, .operandB,
        .writeEnable, .writeIndex, .writeData
    );

    aluUnit u_aluUnit (
        .clock, .reset, .operandA, .operandB, .aluSelect, .flagEnable,
        .aluResult, .zeroFlag
    );

    dataAccess u_dataAccess (
        .clock, .reset, .loadRequest, .storeRequest, .dataAddress, .storeData,
        .accessDone, .loadData, .bus(dataBus)
    );

    memoryArbiter u_memoryArbiter (
        .fetchBus, .dataBus, .memAddress, .memWrite, .memWriteData, .memReadData
    );

endmodule

/* memoryArbiter.sv */
`timescale 1ns/1ps
module memoryArbiter
    import cpuPkg::*;
(
    memBusIf.arbiter fetchBus,
    memBusIf.arbiter dataBus,
    output addrWord  memAddress,
    output logic     memWrite,
    output dataWord  memWriteData,
    input  dataWord  memReadData
);

    logic dataSelected;

    assign dataSelected = dataBus.request;  // Data access always wins

    assign dataBus.grant  = dataBus.request;
    assign fetchBus.grant = fetchBus.request && !dataSelected;

    assign memAddress   = dataSelected ? dataBus.address : fetchBus.address;
    assign memWriteData = dataSelected ? dataBus.writeData : fetchBus.writeData;
    assign memWrite     = dataSelected ? (dataBus.write && dataBus.grant)
                                       : (fetchBus.write && fetchBus.grant);

    assign fetchBus.readData = memReadData;
    assign dataBus.readData  = memReadData;

endmodule

/* dataAccess.sv */
`timescale 1ns/1ps
module dataAccess
    import cpuPkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    loadRequest,
    input  logic    storeRequest,
    input  addrWord dataAddress,
    input  dataWord storeData,
    output logic    accessDone,
    output dataWord loadData,
    memBusIf.requester bus
);

    logic accessTaken;

    // One transfer per request; a request held past its grant is not repeated
    assign bus.request   = (loadRequest || storeRequest) && !accessTaken;
    assign bus.write     = storeRequest;
    assign bus.address   = dataAddress;
    assign bus.writeData = storeData;

    assign accessDone = bus.request && bus.grant;
    assign loadData   = bus.readData;   // Same-cycle memory read

    always_ff @(posedge clock) begin
        if (reset) begin
            accessTaken <= 1'b0;
        end else begin
            accessTaken <= accessDone;
        end
    end

endmodule

/* aluUnit.sv */
`timescale 1ns/1ps
module aluUnit
    import cpuPkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  dataWord operandA,
    input  dataWord operandB,
    input  aluOp    aluSelect,
    input  logic    flagEnable,
    output dataWord aluResult,
    output logic    zeroFlag
);

    always_comb begin
        case (aluSelect)
            aluPassA: aluResult = operandA;
            aluPassB: aluResult = operandB;
            aluNot:   aluResult = ~operandA;
            aluAdd:   aluResult = operandA + operandB;  // Wraps modulo 256
            aluSub:   aluResult = operandA - operandB;
            aluAnd:   aluResult = operandA & operandB;
            aluOr:    aluResult = operandA | operandB;
            aluLsl:   aluResult = {operandA[6:0], 1'b0};
            aluLsr:   aluResult = {1'b0, operandA[7:1]};
            default:  aluResult = operandA;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            zeroFlag <= 1'b0;
        end else if (flagEnable) begin
            zeroFlag <= (aluResult == '0);
        end
    end

endmodule

/* registerFile.sv */
`timescale 1ns/1ps
module registerFile
    import cpuPkg::*;
#(
    parameter int registerCount = 4
) (
    input  logic    clock,
    input  logic    reset,
    input  regIndex readA,
    input  regIndex readB,
    output dataWord operandA,
    output dataWord operandB,
    input  logic    writeEnable,
    input  regIndex writeIndex,
    input  dataWord writeData
);

    localparam int indexBits = $clog2(registerCount);

    dataWord registers [registerCount];

    // Upper index bits ignored when fewer registers are built
    assign operandA = registers[readA[indexBits-1:0]];
    assign operandB = registers[readB[indexBits-1:0]];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < registerCount; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable) begin
            registers[writeIndex[indexBits-1:0]] <= writeData;
        end
    end

endmodule

/* instructionFetch.sv */
`timescale 1ns/1ps
module instructionFetch
    import cpuPkg::*;
#(
    parameter addrWord resetVector = '0
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     fetchLowStrobe,
    input  logic     fetchHighStrobe,
    input  logic     branchTaken,
    input  addrWord  branchTarget,
    output logic     fetchDone,
    output instrWord instruction,
    memBusIf.requester bus
);

    addrWord pc;

    assign bus.request   = fetchLowStrobe || fetchHighStrobe;
    assign bus.write     = 1'b0;    // Read-only requester
    assign bus.address   = pc;
    assign bus.writeData = '0;

    assign fetchDone = bus.request && bus.grant;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc          <= resetVector;
            instruction <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (fetchDone) begin
            pc <= pc + addrWord'(1);
            if (fetchHighStrobe) begin
                instruction[15:8] <= bus.readData;
            end else begin
                instruction[7:0] <= bus.readData;   // Low byte comes first
            end
        end
    end

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps
module controlUnit
    import cpuPkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  instrWord instruction,
    input  logic     zeroFlag,
    input  logic     fetchDone,
    output logic     fetchLowStrobe,
    output logic     fetchHighStrobe,
    output logic     branchTaken,
    output addrWord  branchTarget,
    output logic     loadRequest,
    output logic     storeRequest,
    output addrWord  dataAddress,
    output dataWord  storeData,
    input  logic     accessDone,
    input  dataWord  loadData,
    output regIndex  readA,
    output regIndex  readB,
    input  dataWord  operandB,
    input  dataWord  aluResult,
    output logic     writeEnable,
    output regIndex  writeIndex,
    output dataWord  writeData,
    output aluOp     aluSelect,
    output logic     flagEnable
);

    seqState state;
    seqState nextState;

    opcodeField opcode;
    regIndex    dstIndex;
    regIndex    src1Index;
    regIndex    src2Index;
    regIndex    regSelect;
    logic       addrMode;
    dataWord    immediate;

    logic isAluInstr;
    logic isLoad;
    logic isStore;
    logic needsMemory;

    assign opcode    = instruction[15:12];
    assign addrMode  = instruction[10];    // 1 selects direct address for LD
    assign dstIndex  = instruction[9:8];
    assign regSelect = instruction[9:8];
    assign src1Index = instruction[5:4];
    assign src2Index = instruction[1:0];
    assign immediate = instruction[7:0];

    assign isAluInstr = opcode inside {opAnd, opOr, opNot, opAdd, opSub, opLsr, opLsl, opMov};
    assign isLoad      = (opcode == opLd);
    assign isStore     = (opcode == opSt);
    assign needsMemory = isStore || (isLoad && addrMode);

    always_comb begin
        case (opcode)
            opAnd:   aluSelect = aluAnd;
            opOr:    aluSelect = aluOr;
            opNot:   aluSelect = aluNot;
            opAdd:   aluSelect = aluAdd;
            opSub:   aluSelect = aluSub;    // src1 minus src2
            opLsr:   aluSelect = aluLsr;
            opLsl:   aluSelect = aluLsl;
            default: aluSelect = aluPassA;  // MOV and non-ALU opcodes
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= fetchLow;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            fetchLow: begin
                if (fetchDone) begin
                    nextState = fetchHigh;
                end
            end
            fetchHigh: begin
                if (fetchDone) begin
                    nextState = execute;
                end
            end
            execute: begin
                nextState = needsMemory ? memAccess : fetchLow;
            end
            memAccess: begin
                if (accessDone) begin
                    nextState = fetchLow;
                end
            end
            default: nextState = fetchLow;
        endcase
    end

    assign fetchLowStrobe  = (state == fetchLow);
    assign fetchHighStrobe = (state == fetchHigh);

    // BNE falls through when the last ALU result was zero
    assign branchTaken  = (state == execute)
                        && ((opcode == opBra) || ((opcode == opBne) && !zeroFlag));
    assign branchTarget = immediate;

    assign loadRequest  = (state == memAccess) && isLoad;
    assign storeRequest = (state == memAccess) && isStore;
    assign dataAddress  = immediate;
    assign storeData    = operandB;

    assign readA = src1Index;
    assign readB = isStore ? regSelect : src2Index;   // ST drives its register through port B

    assign flagEnable  = (state == execute) && isAluInstr;
    assign writeEnable = ((state == execute) && (isAluInstr || (isLoad && !addrMode)))
                       || (loadRequest && accessDone);
    assign writeIndex  = dstIndex;
    assign writeData   = isAluInstr ? aluResult : (addrMode ? loadData : immediate);

endmodule

/* memBusIf.sv */
`timescale 1ns/1ps
interface memBusIf
    import cpuPkg::*;
    ();

    logic    request;
    logic    write;
    addrWord address;
    dataWord writeData;
    dataWord readData;
    logic    grant;     // Transfer completes on the edge where this is high

    modport requester (
        output request,
        output write,
        output address,
        output writeData,
        input  readData,
        input  grant
    );

    modport arbiter (
        input  request,
        input  write,
        input  address,
        input  writeData,
        output readData,
        output grant
    );

endinterface

/* cpuPkg.sv */
package cpuPkg;

    typedef logic [7:0]  dataWord;
    typedef logic [7:0]  addrWord;
    typedef logic [15:0] instrWord;
    typedef logic [3:0]  opcodeField;
    typedef logic [1:0]  regIndex;
    typedef logic [3:0]  aluOp;

    localparam opcodeField opAnd = 4'd0;
    localparam opcodeField opOr  = 4'd1;
    localparam opcodeField opNot = 4'd2;
    localparam opcodeField opAdd = 4'd3;
    localparam opcodeField opSub = 4'd4;
    localparam opcodeField opLsr = 4'd5;
    localparam opcodeField opLsl = 4'd6;
    localparam opcodeField opBra = 4'd9;
    localparam opcodeField opBne = 4'd10;
    localparam opcodeField opMov = 4'd11;
    localparam opcodeField opLd  = 4'd12;
    localparam opcodeField opSt  = 4'd13;

    // ALU function codes
    localparam aluOp aluPassA = 4'd0;
    localparam aluOp aluPassB = 4'd1;
    localparam aluOp aluNot   = 4'd2;
    localparam aluOp aluAdd   = 4'd4;
    localparam aluOp aluSub   = 4'd5;
    localparam aluOp aluAnd   = 4'd7;
    localparam aluOp aluOr    = 4'd8;
    localparam aluOp aluLsl   = 4'd11;
    localparam aluOp aluLsr   = 4'd12;

    typedef enum logic [1:0] {
        fetchLow,
        fetchHigh,
        execute,
        memAccess
    } seqState;

endpackage
